//--- memory_pkg.sv
// L1 data cache geometry constants and the shared line, tag, set and dirty-vector types
`default_nettype none

package memory_pkg;

  // Cache organization
  localparam int DCACHE_L1_ASSOCIATIVITY = 4;
  localparam int DCACHE_L1_SETS          = 16;

  // Index widths follow the geometry
  localparam int SET_IDX_W = $clog2(DCACHE_L1_SETS);
  localparam int WAY_IDX_W = $clog2(DCACHE_L1_ASSOCIATIVITY);

  // Payload widths
  localparam int TAG_W  = 20;
  localparam int LINE_W = 128;

  // One dirty bit per way, bit k belongs to way k
  typedef logic [DCACHE_L1_ASSOCIATIVITY-1:0] dirty_vec_t;

  // Set and way selectors
  typedef logic [SET_IDX_W-1:0] set_idx_t;
  typedef logic [WAY_IDX_W-1:0] way_idx_t;

  // Line tag and line data
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [LINE_W-1:0] line_t;

  // Line address toward L2
  // Tag in the upper bits, set index below it
  typedef logic [TAG_W+SET_IDX_W-1:0] l2_addr_t;

endpackage

`default_nettype wire

//--- d1_dirty_vec_one_hotter.sv
// Dirty vector one-hotter, keeps the lowest dirty way and enables the flush set counter
`default_nettype none

module d1_dirty_vec_one_hotter (
  // High in the cycle the engine pushes a line into the buffer
  input  logic                   l2_update_is_writing_wbb_i,
  // Dirty bits of the set under scan, any number set
  input  memory_pkg::dirty_vec_t mh_dirty_vec_i,
  // Lowest dirty way only
  output memory_pkg::dirty_vec_t oh_dirty_vec_o,
  output logic                   at_least_one_dirty_o,
  // Lets the engine move on to the next set
  output logic                   l2_update_cnt_en_o
);

  import memory_pkg::*;

  dirty_vec_t lowest_dirty;
  logic       set_clean;
  logic       single_dirty;

  // Two's complement trick isolates the lowest set bit
  assign lowest_dirty = mh_dirty_vec_i & (~mh_dirty_vec_i + dirty_vec_t'(1));

  // No way of the set holds modified data
  assign set_clean = (mh_dirty_vec_i == '0);

  // Only one way left, the chosen one is the whole vector
  assign single_dirty = (mh_dirty_vec_i == lowest_dirty) && !set_clean;

  assign at_least_one_dirty_o = !set_clean;

  // Advance on a clean set
  // or when the last dirty way leaves for the buffer in this cycle
  assign l2_update_cnt_en_o = set_clean || (single_dirty && l2_update_is_writing_wbb_i);

  assign oh_dirty_vec_o = lowest_dirty;

endmodule

`default_nettype wire

//--- d1_line_store.sv
// L1 line storage with tag, data and dirty bits per set and way, store port and registered read
`default_nettype none

module d1_line_store (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Store port, writes a whole line and marks it dirty
  input  logic                   st_i,
  input  memory_pkg::set_idx_t   st_set_i,
  input  memory_pkg::way_idx_t   st_way_i,
  input  memory_pkg::tag_t       st_tag_i,
  input  memory_pkg::line_t      st_line_i,
  // Dirty vector of one set, straight from the flops
  input  memory_pkg::set_idx_t   dv_set_i,
  output memory_pkg::dirty_vec_t dv_o,
  // Line read, data one cycle after rd_en_i
  input  logic                   rd_en_i,
  input  memory_pkg::set_idx_t   rd_set_i,
  input  memory_pkg::way_idx_t   rd_way_i,
  output memory_pkg::tag_t       rd_tag_o,
  output memory_pkg::line_t      rd_line_o,
  // Dirty clear, one-hot way select
  input  logic                   clr_en_i,
  input  memory_pkg::set_idx_t   clr_set_i,
  input  memory_pkg::dirty_vec_t clr_oh_i
);

  import memory_pkg::*;

  // Tag and data arrays
  tag_t  tag_mem  [DCACHE_L1_SETS][DCACHE_L1_ASSOCIATIVITY];
  line_t line_mem [DCACHE_L1_SETS][DCACHE_L1_ASSOCIATIVITY];

  // Dirty bits, one vector per set
  dirty_vec_t dirty_q [DCACHE_L1_SETS];

  tag_t  rd_tag_q;
  line_t rd_line_q;

  // Array write on a store
  always_ff @(posedge clk_i) begin
    if (st_i) begin
      tag_mem[st_set_i][st_way_i]  <= st_tag_i;
      line_mem[st_set_i][st_way_i] <= st_line_i;
    end
  end

  // Dirty bits
  // Store sets its way, clear drops the named way
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < DCACHE_L1_SETS; s++) begin
        dirty_q[s] <= '0;
      end
    end else begin
      if (st_i) begin
        dirty_q[st_set_i][st_way_i] <= 1'b1;
      end
      if (clr_en_i) begin
        dirty_q[clr_set_i] <= dirty_q[clr_set_i] & ~clr_oh_i;
      end
    end
  end

  // Registered line read, output holds between reads
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_tag_q  <= tag_mem[rd_set_i][rd_way_i];
      rd_line_q <= line_mem[rd_set_i][rd_way_i];
    end
  end

  assign dv_o      = dirty_q[dv_set_i];
  assign rd_tag_o  = rd_tag_q;
  assign rd_line_o = rd_line_q;

  // Store path and flush engine never touch the same set together
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(st_i && clr_en_i && (st_set_i == clr_set_i)));

  // Engine clears exactly one way at a time
  assert property (@(posedge clk_i) disable iff (reset_i)
    clr_en_i |-> $onehot(clr_oh_i));

endmodule

`default_nettype wire

//--- d1_l2_update.sv
// L2 update engine that walks all sets on a flush and moves dirty lines into the write-back buffer
`default_nettype none

module d1_l2_update (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Flush control
  input  logic                   flush_i,
  output logic                   busy_o,
  output logic                   done_o,
  // Set under scan
  output memory_pkg::set_idx_t   set_o,
  // From the one-hotter
  input  memory_pkg::dirty_vec_t oh_dirty_vec_i,
  input  logic                   at_least_one_dirty_i,
  input  logic                   l2_update_cnt_en_i,
  // To the one-hotter
  output logic                   is_writing_wbb_o,
  // Line read toward the line store
  output logic                   rd_en_o,
  output memory_pkg::way_idx_t   rd_way_o,
  input  memory_pkg::tag_t       rd_tag_i,
  input  memory_pkg::line_t      rd_line_i,
  // Dirty clear
  output logic                   clr_en_o,
  output memory_pkg::dirty_vec_t clr_oh_o,
  // Write-back buffer push
  input  logic                   wbb_full_i,
  output logic                   wbb_push_o,
  output memory_pkg::l2_addr_t   wbb_addr_o,
  output memory_pkg::line_t      wbb_line_o
);

  import memory_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SCAN,
    ST_WRITE
  } state_t;

  state_t   state_q;
  set_idx_t set_q;
  logic     done_q;

  way_idx_t oh_way;
  logic     last_set;
  logic     push;
  logic     cnt_adv;

  // One-hot way to binary index
  always_comb begin
    oh_way = '0;
    for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
      if (oh_dirty_vec_i[k]) begin
        oh_way = way_idx_t'(k);
      end
    end
  end

  assign last_set = (set_q == set_idx_t'(DCACHE_L1_SETS - 1));

  // Push only when the buffer has room since read data is ready in WRITE
  assign push = (state_q == ST_WRITE) && !wbb_full_i;

  // Counter moves on the one-hotter's word and never while idle
  assign cnt_adv = (state_q != ST_IDLE) && l2_update_cnt_en_i;

  // State machine and set counter
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      set_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      // Pulse one cycle after leaving the last set
      done_q <= cnt_adv && last_set;
      if (cnt_adv) begin
        set_q <= set_q + set_idx_t'(1);
      end
      case (state_q)
        ST_IDLE: begin
          if (flush_i) begin
            state_q <= ST_SCAN;
            set_q   <= '0;
          end
        end
        ST_SCAN: begin
          // Read issued this cycle for the lowest dirty way
          if (at_least_one_dirty_i) begin
            state_q <= ST_WRITE;
          end else if (last_set) begin
            state_q <= ST_IDLE;
          end
        end
        ST_WRITE: begin
          // Stall here while the buffer is full
          if (push) begin
            state_q <= (cnt_adv && last_set) ? ST_IDLE : ST_SCAN;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign busy_o = (state_q != ST_IDLE) || done_q;
  assign done_o = done_q;
  assign set_o  = set_q;

  assign rd_en_o  = (state_q == ST_SCAN) && at_least_one_dirty_i;
  assign rd_way_o = oh_way;

  // Same chosen way as in SCAN since no store arrives during a flush
  assign is_writing_wbb_o = push;
  assign clr_en_o         = push;
  assign clr_oh_o         = oh_dirty_vec_i;

  assign wbb_push_o = push;
  assign wbb_addr_o = {rd_tag_i, set_q};
  assign wbb_line_o = rd_line_i;

  // A new flush only once the previous one has finished
  assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |-> !busy_o);

  // The way pushed out still holds dirty data
  assert property (@(posedge clk_i) disable iff (reset_i)
    wbb_push_o |-> at_least_one_dirty_i);

endmodule

`default_nettype wire

//--- d1_wbb.sv
// Write-back buffer FIFO that holds flushed lines and drains them to the L2 write port
`default_nettype none

module d1_wbb #(
  parameter int WBB_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Push side, from the flush engine
  input  logic                 push_i,
  input  memory_pkg::l2_addr_t addr_i,
  input  memory_pkg::line_t    line_i,
  output logic                 full_o,
  // L2 side, one line per cycle while ready
  input  logic                 l2_ready_i,
  output logic                 l2_wr_o,
  output memory_pkg::l2_addr_t l2_addr_o,
  output memory_pkg::line_t    l2_line_o
);

  import memory_pkg::*;

  localparam int PTR_W = (WBB_DEPTH > 1) ? $clog2(WBB_DEPTH) : 1;
  localparam int CNT_W = $clog2(WBB_DEPTH + 1);

  // Entry storage
  l2_addr_t addr_mem [WBB_DEPTH];
  line_t    line_mem [WBB_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic pop;

  // Oldest entry leaves whenever L2 takes it
  assign pop    = l2_ready_i && (count_q != '0);
  assign full_o = (count_q == CNT_W'(WBB_DEPTH));

  // Entry write
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr_q] <= addr_i;
      line_mem[wr_ptr_q] <= line_i;
    end
  end

  // Pointers wrap at the depth, count tracks occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(WBB_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(WBB_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // Push and pop together leave the count unchanged
      if (push_i && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push_i) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  assign l2_wr_o   = pop;
  assign l2_addr_o = addr_mem[rd_ptr_q];
  assign l2_line_o = line_mem[rd_ptr_q];

  // Engine has to respect full
  assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full_o);

  assert property (@(posedge clk_i) disable iff (reset_i)
    count_q <= CNT_W'(WBB_DEPTH));

endmodule

`default_nettype wire

//--- d1_flush_top.sv
// L1 flush path top level joining line store, one-hotter, update engine and write-back buffer
`default_nettype none

module d1_flush_top #(
  parameter int WBB_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Store port
  input  logic                 st_i,
  input  memory_pkg::set_idx_t st_set_i,
  input  memory_pkg::way_idx_t st_way_i,
  input  memory_pkg::tag_t     st_tag_i,
  input  memory_pkg::line_t    st_line_i,
  // Flush control
  input  logic                 flush_i,
  output logic                 busy_o,
  output logic                 done_o,
  // L2 write port
  input  logic                 l2_ready_i,
  output logic                 l2_wr_o,
  output memory_pkg::l2_addr_t l2_addr_o,
  output memory_pkg::line_t    l2_line_o
);

  import memory_pkg::*;

  // Engine set, shared by dirty read, line read and clear
  set_idx_t   upd_set;
  dirty_vec_t mh_dirty_vec;
  dirty_vec_t oh_dirty_vec;
  logic       at_least_one_dirty;
  logic       l2_update_cnt_en;
  logic       l2_update_is_writing_wbb;

  logic       rd_en;
  way_idx_t   rd_way;
  tag_t       rd_tag;
  line_t      rd_line;

  logic       clr_en;
  dirty_vec_t clr_oh;

  logic       wbb_push;
  logic       wbb_full;
  l2_addr_t   wbb_addr;
  line_t      wbb_line;

  d1_line_store u_line_store (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .st_i      (st_i),
    .st_set_i  (st_set_i),
    .st_way_i  (st_way_i),
    .st_tag_i  (st_tag_i),
    .st_line_i (st_line_i),
    .dv_set_i  (upd_set),
    .dv_o      (mh_dirty_vec),
    .rd_en_i   (rd_en),
    .rd_set_i  (upd_set),
    .rd_way_i  (rd_way),
    .rd_tag_o  (rd_tag),
    .rd_line_o (rd_line),
    .clr_en_i  (clr_en),
    .clr_set_i (upd_set),
    .clr_oh_i  (clr_oh)
  );

  d1_dirty_vec_one_hotter u_one_hotter (
    .l2_update_is_writing_wbb_i (l2_update_is_writing_wbb),
    .mh_dirty_vec_i             (mh_dirty_vec),
    .oh_dirty_vec_o             (oh_dirty_vec),
    .at_least_one_dirty_o       (at_least_one_dirty),
    .l2_update_cnt_en_o         (l2_update_cnt_en)
  );

  d1_l2_update u_l2_update (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .flush_i              (flush_i),
    .busy_o               (busy_o),
    .done_o               (done_o),
    .set_o                (upd_set),
    .oh_dirty_vec_i       (oh_dirty_vec),
    .at_least_one_dirty_i (at_least_one_dirty),
    .l2_update_cnt_en_i   (l2_update_cnt_en),
    .is_writing_wbb_o     (l2_update_is_writing_wbb),
    .rd_en_o              (rd_en),
    .rd_way_o             (rd_way),
    .rd_tag_i             (rd_tag),
    .rd_line_i            (rd_line),
    .clr_en_o             (clr_en),
    .clr_oh_o             (clr_oh),
    .wbb_full_i           (wbb_full),
    .wbb_push_o           (wbb_push),
    .wbb_addr_o           (wbb_addr),
    .wbb_line_o           (wbb_line)
  );

  d1_wbb #(
    .WBB_DEPTH (WBB_DEPTH)
  ) u_wbb (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (wbb_push),
    .addr_i     (wbb_addr),
    .line_i     (wbb_line),
    .full_o     (wbb_full),
    .l2_ready_i (l2_ready_i),
    .l2_wr_o    (l2_wr_o),
    .l2_addr_o  (l2_addr_o),
    .l2_line_o  (l2_line_o)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// Testbench clock and synchronous reset generator for the flush path testbench
`default_nettype none

module tb_clk_gen #(
  parameter int CLK_PERIOD   = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset spans RESET_CYCLES rising edges, released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_d1_flush.sv
// Testbench for the L1 flush path that replays vector records and checks every L2 write-back
`default_nettype none

module tb_d1_flush;

  timeunit 1ns;
  timeprecision 1ps;

  import memory_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int WBB_DEPTH     = 4;
  localparam int MAX_RECORDS   = 64;
  localparam int REC_WORDS     = 8;
  localparam int SETTLE_CYCLES = 8;
  // Worst case cycles for one flush with every way of every set dirty and stalled
  localparam int TEST_CYCLE_BOUND =
    (DCACHE_L1_SETS + 4 * DCACHE_L1_ASSOCIATIVITY * DCACHE_L1_SETS) * 20;
  localparam logic [31:0] RAND_SEED = 32'h70e02c6a;

  // Record opcodes
  localparam logic [31:0] OP_END   = 32'd0;
  localparam logic [31:0] OP_STORE = 32'd1;
  localparam logic [31:0] OP_FLUSH = 32'd2;
  localparam logic [31:0] OP_READY = 32'd3;

  logic     clk;
  logic     reset;
  logic     st;
  set_idx_t st_set;
  way_idx_t st_way;
  tag_t     st_tag;
  line_t    st_line;
  logic     flush;
  logic     busy;
  logic     done;
  logic     l2_ready;
  logic     l2_wr;
  l2_addr_t l2_addr;
  line_t    l2_line;

  // Eight raw vector words per record
  logic [31:0] vec_mem [MAX_RECORDS * REC_WORDS];

  // Reference model of the cache contents
  logic  model_dirty [DCACHE_L1_SETS][DCACHE_L1_ASSOCIATIVITY];
  tag_t  model_tag   [DCACHE_L1_SETS][DCACHE_L1_ASSOCIATIVITY];
  line_t model_line  [DCACHE_L1_SETS][DCACHE_L1_ASSOCIATIVITY];

  l2_addr_t exp_addr_q [$];
  line_t    exp_line_q [$];
  l2_addr_t got_addr_q [$];
  line_t    got_line_q [$];

  // L2 ready pattern
  logic ready_random;
  int   low_hold;
  int   low_left;

  int     test_errors;
  int     tests_passed;
  int     tests_failed;
  int     other_errors;
  int     num_tests;
  longint wd_limit_ns;
  logic   wd_armed;

  tb_clk_gen #(
    .CLK_PERIOD   (CLK_PERIOD),
    .RESET_CYCLES (3)
  ) u_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  d1_flush_top #(
    .WBB_DEPTH (WBB_DEPTH)
  ) DUT (
    .clk_i      (clk),
    .reset_i    (reset),
    .st_i       (st),
    .st_set_i   (st_set),
    .st_way_i   (st_way),
    .st_tag_i   (st_tag),
    .st_line_i  (st_line),
    .flush_i    (flush),
    .busy_o     (busy),
    .done_o     (done),
    .l2_ready_i (l2_ready),
    .l2_wr_o    (l2_wr),
    .l2_addr_o  (l2_addr),
    .l2_line_o  (l2_line)
  );

  // Collect every L2 write beat
  always @(posedge clk) begin
    if (!reset && l2_wr) begin
      got_addr_q.push_back(l2_addr);
      got_line_q.push_back(l2_line);
    end
  end

  // Ends a stuck run
  initial begin
    wait (wd_armed);
    #(wd_limit_ns);
    $display("watchdog expired after %0d ns, the run did not finish", wd_limit_ns);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Step to the next falling edge and update the ready level
  task automatic next_cycle();
    logic [31:0] rnd;
    @(negedge clk);
    if (low_left > 0) begin
      l2_ready = 1'b0;
      low_left--;
    end else if (ready_random) begin
      rnd      = $urandom;
      l2_ready = rnd[0];
    end else begin
      l2_ready = 1'b1;
    end
  endtask

  task automatic check_addr(input string name, input l2_addr_t exp, input l2_addr_t act);
    if (exp !== act) begin
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_line(input string name, input line_t exp, input line_t act);
    if (exp !== act) begin
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, exp, act);
      test_errors++;
    end
  endtask

  // One store pulse mirrored into the model
  task automatic store_line(input set_idx_t set, input way_idx_t way, input tag_t tag,
                            input line_t line);
    next_cycle();
    st      = 1'b1;
    st_set  = set;
    st_way  = way;
    st_tag  = tag;
    st_line = line;
    model_dirty[set][way] = 1'b1;
    model_tag[set][way]   = tag;
    model_line[set][way]  = line;
    next_cycle();
    st = 1'b0;
  endtask

  // Flush and wait for done and the writes before comparing against the model
  task automatic run_flush(input int test_no);
    int waited;
    int n_check;
    exp_addr_q.delete();
    exp_line_q.delete();
    // Ascending set and ascending way within a set
    for (int s = 0; s < DCACHE_L1_SETS; s++) begin
      for (int w = 0; w < DCACHE_L1_ASSOCIATIVITY; w++) begin
        if (model_dirty[s][w]) begin
          exp_addr_q.push_back({model_tag[s][w], set_idx_t'(s)});
          exp_line_q.push_back(model_line[s][w]);
          model_dirty[s][w] = 1'b0;
        end
      end
    end
    test_errors = 0;
    got_addr_q.delete();
    got_line_q.delete();
    low_left = low_hold;
    next_cycle();
    // Engine idle before the flush pulse
    check_flag("busy_o", 1'b0, busy);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    waited = 0;
    while (!done && waited < TEST_CYCLE_BOUND) begin
      check_flag("busy_o", 1'b1, busy);
      next_cycle();
      waited++;
    end
    if (!done) begin
      $display("test %0d: done never asserted within %0d cycles", test_no, TEST_CYCLE_BOUND);
      test_errors++;
    end else begin
      // busy_o still covers the done_o cycle
      check_flag("busy_o", 1'b1, busy);
      next_cycle();
      // Single cycle done pulse with busy_o dropping right after
      check_flag("done_o", 1'b0, done);
      check_flag("busy_o", 1'b0, busy);
      // done may lead the buffer drain
      waited = 0;
      while (got_addr_q.size() < exp_addr_q.size() && waited < TEST_CYCLE_BOUND) begin
        next_cycle();
        waited++;
      end
      // Extra cycles catch duplicated writes
      repeat (SETTLE_CYCLES) next_cycle();
      if (got_addr_q.size() < exp_addr_q.size()) begin
        $display("test %0d: missing writes, only %0d of %0d lines reached L2",
                 test_no, got_addr_q.size(), exp_addr_q.size());
        test_errors++;
      end
      check_count("l2_wr_o beats", exp_addr_q.size(), got_addr_q.size());
      n_check = (got_addr_q.size() < exp_addr_q.size()) ? got_addr_q.size() : exp_addr_q.size();
      for (int i = 0; i < n_check; i++) begin
        check_addr("l2_addr_o", exp_addr_q[i], got_addr_q[i]);
        check_line("l2_line_o", exp_line_q[i], got_line_q[i]);
      end
    end
    $display("test %0d: %0d writes expected, %0d received, %0d errors",
             test_no, exp_addr_q.size(), got_addr_q.size(), test_errors);
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
  endtask

  initial begin
    int   rec;
    int   base;
    int   test_no;
    logic at_end;
    st           = 1'b0;
    st_set       = '0;
    st_way       = '0;
    st_tag       = '0;
    st_line      = '0;
    flush        = 1'b0;
    l2_ready     = 1'b1;
    ready_random = 1'b0;
    low_hold     = 0;
    low_left     = 0;
    tests_passed = 0;
    tests_failed = 0;
    other_errors = 0;
    test_errors  = 0;
    wd_armed     = 1'b0;
    for (int s = 0; s < DCACHE_L1_SETS; s++) begin
      for (int w = 0; w < DCACHE_L1_ASSOCIATIVITY; w++) begin
        model_dirty[s][w] = 1'b0;
        model_tag[s][w]   = '0;
        model_line[s][w]  = '0;
      end
    end
    void'($urandom(RAND_SEED));
    for (int i = 0; i < MAX_RECORDS * REC_WORDS; i++) begin
      vec_mem[i] = '0;
    end
    $readmemh("flush_vectors.txt", vec_mem);

    // Every flush record is one test
    num_tests = 0;
    for (int r = 0; r < MAX_RECORDS; r++) begin
      if (vec_mem[r * REC_WORDS] == OP_FLUSH) begin
        num_tests++;
      end
    end
    wd_limit_ns = longint'(num_tests + 1) * TEST_CYCLE_BOUND * CLK_PERIOD;
    wd_armed    = 1'b1;

    @(negedge reset);
    rec     = 0;
    test_no = 0;
    at_end  = 1'b0;
    while (!at_end && rec < MAX_RECORDS) begin
      base = rec * REC_WORDS;
      case (vec_mem[base])
        OP_END: at_end = 1'b1;
        OP_STORE: begin
          store_line(vec_mem[base + 1][SET_IDX_W-1:0], vec_mem[base + 2][WAY_IDX_W-1:0],
                     vec_mem[base + 3][TAG_W-1:0],
                     {vec_mem[base + 4], vec_mem[base + 5], vec_mem[base + 6],
                      vec_mem[base + 7]});
        end
        OP_FLUSH: begin
          test_no++;
          run_flush(test_no);
        end
        OP_READY: begin
          ready_random = vec_mem[base + 1][0];
          low_hold     = int'(vec_mem[base + 2]);
        end
        default: begin
          $display("record %0d holds an unknown opcode %h", rec, vec_mem[base]);
          other_errors++;
        end
      endcase
      rec++;
    end

    $display("summary: %0d tests, %0d passed, %0d failed",
             tests_passed + tests_failed, tests_passed, tests_failed);
    if (tests_failed == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flush_vectors.txt
// op a b c line[127:96] line[95:64] line[63:32] line[31:0], all hex
// op 1 store a=set b=way c=tag, op 2 flush, op 3 ready a=random b=low cycles, op 0 end
// Flush of a clean cache
2 0 0 0 00000000 00000000 00000000 00000000
// One line
1 5 2 abcde 11111111 22222222 33333333 44444444
2 0 0 0 00000000 00000000 00000000 00000000
// Scattered lines, set 3 dirty in all ways
1 f 2 0f002 0f020f02 a5a5a5a5 5a5a5a5a 000f0002
1 3 3 03003 03030303 33333333 c3c3c3c3 00030003
1 0 1 00001 00010001 deadbeef cafef00d 00000001
1 3 0 03000 03000300 12345678 9abcdef0 00030000
1 9 1 09001 09010901 0badf00d feedface 00090001
1 3 2 03002 03020302 55555555 aaaaaaaa 00030002
1 f 0 0f000 0f000f00 76543210 fedcba98 000f0000
1 3 1 03001 03010301 13579bdf 2468ace0 00030001
1 7 3 07003 07030703 c0ffee00 0ddba11d 00070003
2 0 0 0 00000000 00000000 00000000 00000000
// L2 not ready for 40 cycles, random afterwards
3 1 28 0 00000000 00000000 00000000 00000000
1 1 0 a1000 a1000a10 01010101 10101010 00010000
1 1 3 a1003 a1003a10 01010303 30303030 00010003
1 2 1 a2001 a2001a20 02020101 10102020 00020001
1 2 2 a2002 a2002a20 02020202 20202020 00020002
1 6 0 a6000 a6000a60 06060000 00000606 00060000
1 6 1 a6001 a6001a60 06060101 01010606 00060001
1 6 2 a6002 a6002a60 06060202 02020606 00060002
1 6 3 a6003 a6003a60 06060303 03030606 00060003
1 c 2 ac002 ac002ac0 0c0c0202 02020c0c 000c0002
1 e 1 ae001 ae001ae0 0e0e0101 01010e0e 000e0001
2 0 0 0 00000000 00000000 00000000 00000000
3 0 0 0 00000000 00000000 00000000 00000000
// Overwrite of one line, then a second flush on a clean cache
1 4 1 44441 44444444 11111111 44444444 11111111
1 4 1 b4441 bbbbbbbb 44444444 bbbbbbbb 44444444
2 0 0 0 00000000 00000000 00000000 00000000
2 0 0 0 00000000 00000000 00000000 00000000
0 0 0 0 00000000 00000000 00000000 00000000

//--- flist.f
memory_pkg.sv
d1_dirty_vec_one_hotter.sv
d1_line_store.sv
d1_l2_update.sv
d1_wbb.sv
d1_flush_top.sv
tb_clk_gen.sv
tb_d1_flush.sv

//--- Makefile
TOP := tb_d1_flush

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --assert -f flist.f --top-module $(TOP) -o sim_$(TOP) --Mdir obj_dir
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || echo "TEST RESULT: FAIL" >> sim.log
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
